/* design/mac_config.svh */
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Each operand. The tree wiring assumes 6.
`define MAC_OPERAND_WIDTH 6

// Full product of two operands.
`define MAC_PRODUCT_WIDTH 12

`define MAC_ACC_WIDTH 16 // Accumulator and result.

`endif

/* design/macPkg.sv */
`include "mac_config.svh"

package macPkg;

  // ----------------------------------------------------------------------
  // Command opcodes
  // ----------------------------------------------------------------------

  typedef enum logic [1:0]
  {
    OP_NOP = 2'b00, // No effect, no result.
    OP_MUL = 2'b01, // Load product.
    OP_MAC = 2'b10, // Add product.
    OP_CLR = 2'b11  // Clear accumulator and overflow.
  } macOp;

  // ----------------------------------------------------------------------
  // Multiplier datapath types
  // ----------------------------------------------------------------------

  // Sum and carry rows leaving the tree, weight aligned to the product.
  typedef logic [`MAC_PRODUCT_WIDTH-1:0] productRow;

  // One partial product per multiplier bit, row i has weight 2^i.
  typedef logic [`MAC_OPERAND_WIDTH-1:0][`MAC_OPERAND_WIDTH-1:0] ppRows;

endpackage

/* design/reduceIf.sv */
`timescale 1ns/1ps

interface reduceIf;
  import macPkg::*;

  productRow sumRow;   // Registered sum row.
  productRow carryRow; // Registered carry row.
  logic stageValid;    // Command sampled one edge ago.
  macOp stageOp;       // Its opcode.

  modport tree
  (
    output sumRow,
    output carryRow
  );

  modport ctrl
  (
    output stageValid,
    output stageOp
  );

  modport acc
  (
    input sumRow,
    input carryRow,
    input stageValid,
    input stageOp
  );

endinterface

/* design/partialProducts.sv */
`timescale 1ns/1ps

`include "mac_config.svh"

module partialProducts
(
  input  logic [`MAC_OPERAND_WIDTH-1:0] a,
  input  logic [`MAC_OPERAND_WIDTH-1:0] b,
  output macPkg::ppRows                 rows
);

  // ----------------------------------------------------------------------
  // AND array
  // ----------------------------------------------------------------------

  // Row i is the multiplicand gated by multiplier bit i.
  always_comb
  begin
    for (int i = 0; i < `MAC_OPERAND_WIDTH; i++)
    begin
      rows[i] = a & {`MAC_OPERAND_WIDTH{b[i]}};
    end
  end

endmodule

/* design/wallaceTree.sv */
`timescale 1ns/1ps

`include "mac_config.svh"

module wallaceTree
(
  input  logic          clk,
  input  logic          rst,
  input  macPkg::ppRows rows,
  reduceIf.tree         red
);
  import macPkg::*;

  // Bit rows[k][j] carries weight j+k.
  logic l0Ha1S, l0Ha1C, l0Fa1S, l0Fa1C, l0Fa2S, l0Fa2C;
  logic l0Fa3S, l0Fa3C, l0Fa4S, l0Fa4C, l0Ha2S, l0Ha2C;
  logic l1Ha1S, l1Ha1C, l1Fa1S, l1Fa1C, l1Fa2S, l1Fa2C;
  logic l1Fa3S, l1Fa3C, l1Fa4S, l1Fa4C, l1Ha2S, l1Ha2C;
  logic l2Ha1S, l2Ha1C, l2Fa1S, l2Fa1C, l2Fa2S, l2Fa2C;
  logic l2Fa3S, l2Fa3C, l2Fa4S, l2Fa4C, l2Fa5S, l2Fa5C;
  logic l3Ha1S, l3Ha1C, l3Ha2S, l3Ha2C, l3Fa1S, l3Fa1C;
  logic l3Fa2S, l3Fa2C, l3Fa3S, l3Fa3C, l3Fa4S, l3Fa4C;
  logic l3Ha4S, l3Ha4C, l3Ha5S, l3Ha5C;

  productRow sumComb;
  productRow carryComb;

  task automatic halfAdder(input logic x, y, output logic s, c);
    s = x ^ y;
    c = x & y;
  endtask

  task automatic fullAdder(input logic x, y, z, output logic s, c);
    logic w;
    w = x ^ y;
    s = w ^ z;
    c = (w & z) | (x & y);
  endtask

  // ----------------------------------------------------------------------
  // Reduction levels
  // ----------------------------------------------------------------------

  always_comb
  begin
    // Level 0 folds rows 0 to 2.
    halfAdder(rows[0][1], rows[1][0], l0Ha1S, l0Ha1C);
    fullAdder(rows[0][2], rows[1][1], rows[2][0], l0Fa1S, l0Fa1C);
    fullAdder(rows[0][3], rows[1][2], rows[2][1], l0Fa2S, l0Fa2C);
    fullAdder(rows[0][4], rows[1][3], rows[2][2], l0Fa3S, l0Fa3C);
    fullAdder(rows[0][5], rows[1][4], rows[2][3], l0Fa4S, l0Fa4C);
    halfAdder(rows[1][5], rows[2][4], l0Ha2S, l0Ha2C);

    // Level 1 folds rows 3 to 5.
    halfAdder(rows[3][1], rows[4][0], l1Ha1S, l1Ha1C);
    fullAdder(rows[3][2], rows[4][1], rows[5][0], l1Fa1S, l1Fa1C);
    fullAdder(rows[3][3], rows[4][2], rows[5][1], l1Fa2S, l1Fa2C);
    fullAdder(rows[3][4], rows[4][3], rows[5][2], l1Fa3S, l1Fa3C);
    fullAdder(rows[3][5], rows[4][4], rows[5][3], l1Fa4S, l1Fa4C);
    halfAdder(rows[4][5], rows[5][4], l1Ha2S, l1Ha2C);

    halfAdder(l0Ha1C, l0Fa1S, l2Ha1S, l2Ha1C);
    fullAdder(l0Fa1C, l0Fa2S, rows[3][0], l2Fa1S, l2Fa1C);
    fullAdder(l0Fa2C, l1Ha1S, l0Fa3S, l2Fa2S, l2Fa2C);
    fullAdder(l0Fa3C, l1Fa1S, l0Fa4S, l2Fa3S, l2Fa3C);
    fullAdder(l0Fa4C, l1Fa2S, l0Ha2S, l2Fa4S, l2Fa4C);
    fullAdder(l0Ha2C, l1Fa3S, rows[2][5], l2Fa5S, l2Fa5C);

    halfAdder(l2Ha1C, l2Fa1S, l3Ha1S, l3Ha1C);
    halfAdder(l2Fa1C, l2Fa2S, l3Ha2S, l3Ha2C);
    fullAdder(l2Fa2C, l1Ha1C, l2Fa3S, l3Fa1S, l3Fa1C);
    fullAdder(l2Fa3C, l1Fa1C, l2Fa4S, l3Fa2S, l3Fa2C);
    fullAdder(l2Fa4C, l1Fa2C, l2Fa5S, l3Fa3S, l3Fa3C);
    fullAdder(l2Fa5C, l1Fa4S, l1Fa3C, l3Fa4S, l3Fa4C); // Column 8 has three bits.
    halfAdder(l1Fa4C, l1Ha2S, l3Ha4S, l3Ha4C);
    halfAdder(l1Ha2C, rows[5][5], l3Ha5S, l3Ha5C);
  end

  // Two rows left, both aligned to product weight.
  always_comb
  begin
    sumComb  = {1'b0, l3Ha5S, l3Ha4S, l3Fa4S, l3Fa3S, l3Fa2S, l3Fa1S,
                l3Ha2S, l3Ha1S, l2Ha1S, l0Ha1S, rows[0][0]};
    carryComb = {l3Ha5C, l3Ha4C, l3Fa4C, l3Fa3C, l3Fa2C, l3Fa1C,
                 l3Ha2C, l3Ha1C, 4'b0000};
  end

  // ----------------------------------------------------------------------
  // Stage-1 pipeline register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      red.sumRow   <= '0;
      red.carryRow <= '0;
    end
    else
    begin
      red.sumRow   <= sumComb;
      red.carryRow <= carryComb;
    end
  end

endmodule

/* design/accumulator.sv */
`timescale 1ns/1ps

`include "mac_config.svh"

module accumulator
(
  input  logic                      clk,
  input  logic                      rst,
  reduceIf.acc                      red,
  input  logic                      accLoad,
  input  logic                      accAdd,
  input  logic                      accClear,
  output logic [`MAC_ACC_WIDTH-1:0] acc,
  output logic                      carryOut
);
  import macPkg::*;

  productRow                 product;
  logic [`MAC_ACC_WIDTH-1:0] productExt;
  logic [`MAC_ACC_WIDTH:0]   addSum;

  // ----------------------------------------------------------------------
  // Carry-propagate adder
  // ----------------------------------------------------------------------

  always_comb
  begin : rippleAdd
    logic c;
    c = 1'b0;
    for (int i = 0; i < `MAC_PRODUCT_WIDTH; i++)
    begin
      product[i] = red.sumRow[i] ^ red.carryRow[i] ^ c;
      c = (red.sumRow[i] & red.carryRow[i]) | ((red.sumRow[i] ^ red.carryRow[i]) & c);
    end
  end

  assign productExt = {{(`MAC_ACC_WIDTH - `MAC_PRODUCT_WIDTH){1'b0}}, product};

  // Bit 16 is the wrap out of the accumulator.
  assign addSum   = {1'b0, acc} + {1'b0, productExt};
  assign carryOut = addSum[`MAC_ACC_WIDTH];

  // ----------------------------------------------------------------------
  // Accumulator register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      acc <= '0;
    end
    else if (accClear)
    begin
      acc <= '0;
    end
    else if (accLoad)
    begin
      acc <= productExt; // MUL.
    end
    else if (accAdd)
    begin
      acc <= addSum[`MAC_ACC_WIDTH-1:0]; // MAC, wraps.
    end
  end

endmodule

/* design/macControl.sv */
`timescale 1ns/1ps

module macControl
(
  input  logic         clk,
  input  logic         rst,
  input  logic         cmdValid,
  input  macPkg::macOp cmdOp,
  reduceIf.ctrl        red,
  input  logic         carryOut,
  output logic         accLoad,
  output logic         accAdd,
  output logic         accClear,
  output logic         resultValid,
  output logic         overflow
);
  import macPkg::*;

  // ----------------------------------------------------------------------
  // Stage 1 command tags
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      red.stageValid <= 1'b0;
      red.stageOp    <= OP_NOP;
    end
    else
    begin
      red.stageValid <= cmdValid;
      red.stageOp    <= cmdOp;
    end
  end

  // ----------------------------------------------------------------------
  // Stage 2 decode
  // ----------------------------------------------------------------------

  always_comb
  begin
    accLoad  = 1'b0;
    accAdd   = 1'b0;
    accClear = 1'b0;
    if (red.stageValid)
    begin
      case (red.stageOp)
        OP_MUL: accLoad = 1'b1;
        OP_MAC: accAdd = 1'b1;
        OP_CLR: accClear = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resultValid <= 1'b0;
      overflow    <= 1'b0;
    end
    else
    begin
      resultValid <= red.stageValid && (red.stageOp != OP_NOP);
      if (accClear)
        overflow <= 1'b0;
      else if (accAdd && carryOut)
        overflow <= 1'b1; // Sticky until CLR.
    end
  end

endmodule

/* design/macTop.sv */
`timescale 1ns/1ps

`include "mac_config.svh"

module macTop
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cmdValid,
  input  macPkg::macOp                  cmdOp,
  input  logic [`MAC_OPERAND_WIDTH-1:0] a,
  input  logic [`MAC_OPERAND_WIDTH-1:0] b,
  output logic [`MAC_ACC_WIDTH-1:0]     result,
  output logic                          resultValid,
  output logic                          overflow
);
  import macPkg::*;

  ppRows rows;
  logic  accLoad;
  logic  accAdd;
  logic  accClear;
  logic  carryOut;

  reduceIf red ();

  // ----------------------------------------------------------------------
  // Stage 1, multiply
  // ----------------------------------------------------------------------

  partialProducts uPartial
  (
    .a    (a),
    .b    (b),
    .rows (rows)
  );

  wallaceTree uTree
  (
    .clk  (clk),
    .rst  (rst),
    .rows (rows),
    .red  (red.tree)
  );

  // ----------------------------------------------------------------------
  // Stage 2, accumulate
  // ----------------------------------------------------------------------

  macControl uControl
  (
    .clk         (clk),
    .rst         (rst),
    .cmdValid    (cmdValid),
    .cmdOp       (cmdOp),
    .red         (red.ctrl),
    .carryOut    (carryOut),
    .accLoad     (accLoad),
    .accAdd      (accAdd),
    .accClear    (accClear),
    .resultValid (resultValid),
    .overflow    (overflow)
  );

  accumulator uAcc
  (
    .clk      (clk),
    .rst      (rst),
    .red      (red.acc),
    .accLoad  (accLoad),
    .accAdd   (accAdd),
    .accClear (accClear),
    .acc      (result),
    .carryOut (carryOut)
  );

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen
(
  output logic clk
);

  localparam int HALF_PERIOD = 50; // 100 ns period.

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

/* tests/macTb.sv */
`timescale 1ns/1ps

`include "mac_config.svh"

module macTb;
  import macPkg::*;

  localparam int OP_W         = `MAC_OPERAND_WIDTH;
  localparam int PROD_W       = `MAC_PRODUCT_WIDTH;
  localparam int ACC_W        = `MAC_ACC_WIDTH;
  localparam int SEED         = 34;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int MUL_COUNT    = 4096;
  localparam int ACC_RUNS     = 8;
  localparam int ACC_LEN      = 40;
  localparam int OVF_LEN      = 40; // Always wraps with operands of 48 and up.
  localparam int MIX_LEN      = 500;
  localparam int DRAIN_STEPS  = 4;
  localparam int LATENCY      = 2;  // Falling edges from drive to visible result.
  localparam int TOTAL_STEPS  = 2 * (RESET_CYCLES + 1) + 2 + MUL_COUNT
                                + ACC_RUNS * (ACC_LEN + 1) + 2 * OVF_LEN + 2 + MIX_LEN
                                + 8 * DRAIN_STEPS;
  localparam int WATCHDOG_NS  = (TOTAL_STEPS + 50) * CLK_PERIOD;

  logic                clk;
  logic                rst;
  logic                cmdValid;
  macOp                cmdOp;
  logic [OP_W-1:0]     a;
  logic [OP_W-1:0]     b;
  logic [ACC_W-1:0]    result;
  logic                resultValid;
  logic                overflow;

  // Reference model and expected results in command order.
  logic [ACC_W-1:0]    modelAcc;
  logic                modelOvf;
  logic [ACC_W-1:0]    expResultQ[$];
  logic                expOvfQ[$];
  int                  dueQ[$];
  int                  cycle;
  int                  valueErrors;
  int                  protocolErrors;
  string               testName;

  clockGen uClock
  (
    .clk (clk)
  );

  macTop dut
  (
    .clk         (clk),
    .rst         (rst),
    .cmdValid    (cmdValid),
    .cmdOp       (cmdOp),
    .a           (a),
    .b           (b),
    .result      (result),
    .resultValid (resultValid),
    .overflow    (overflow)
  );

  // ----------------------------------------------------------------------
  // Model and checks
  // ----------------------------------------------------------------------

  task automatic applyModel(input macOp op, input logic [OP_W-1:0] x, input logic [OP_W-1:0] y);
    logic [PROD_W-1:0] product;
    logic [ACC_W:0]    sum;
    product = {{(PROD_W - OP_W){1'b0}}, x} * {{(PROD_W - OP_W){1'b0}}, y};
    sum = {1'b0, modelAcc} + {{(ACC_W + 1 - PROD_W){1'b0}}, product};
    case (op)
      OP_MUL: modelAcc = {{(ACC_W - PROD_W){1'b0}}, product};
      OP_MAC:
      begin
        modelAcc = sum[ACC_W-1:0];
        if (sum[ACC_W])
          modelOvf = 1'b1;
      end
      OP_CLR:
      begin
        modelAcc = '0;
        modelOvf = 1'b0;
      end
      default: ;
    endcase
  endtask

  task automatic checkOutputs();
    int               due;
    logic [ACC_W-1:0] expRes;
    logic             expOvf;
    if (resultValid === 1'b1)
    begin
      if (dueQ.size() == 0)
      begin
        $display("%s: resultValid pulsed at cycle %0d with no command outstanding",
                 testName, cycle);
        protocolErrors++;
      end
      else
      begin
        due    = dueQ.pop_front();
        expRes = expResultQ.pop_front();
        expOvf = expOvfQ.pop_front();
        if (due != cycle)
        begin
          $display("%s: result seen at cycle %0d but was due at cycle %0d",
                   testName, cycle, due);
          protocolErrors++;
        end
        if (result !== expRes)
        begin
          $display("[FAIL] %s result: expected %0d, actual %0d", testName, expRes, result);
          valueErrors++;
        end
        if (overflow !== expOvf)
        begin
          $display("[FAIL] %s overflow: expected %0d, actual %0d", testName, expOvf, overflow);
          valueErrors++;
        end
      end
    end
    else if (resultValid !== 1'b0)
    begin
      $display("%s: resultValid is unknown at cycle %0d", testName, cycle);
      protocolErrors++;
    end
    else if (dueQ.size() != 0 && dueQ[0] <= cycle)
    begin
      $display("%s: no resultValid for the command due at cycle %0d", testName, dueQ[0]);
      protocolErrors++;
      void'(dueQ.pop_front());
      void'(expResultQ.pop_front());
      void'(expOvfQ.pop_front());
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  // One cycle: check at the falling edge, then drive the next command.
  task automatic issue(input logic v, input macOp op, input logic [OP_W-1:0] x,
                       input logic [OP_W-1:0] y);
    @(negedge clk);
    cycle++;
    checkOutputs();
    if (v && op != OP_NOP)
    begin
      applyModel(op, x, y);
      expResultQ.push_back(modelAcc);
      expOvfQ.push_back(modelOvf);
      dueQ.push_back(cycle + LATENCY);
    end
    cmdValid = v;
    cmdOp    = op;
    a        = x;
    b        = y;
  endtask

  task automatic idle(input int n);
    repeat (n)
      issue(1'b0, OP_NOP, '0, '0);
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", testName, what, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic resetDut();
    rst      = 1'b1;
    cmdValid = 1'b0;
    idle(RESET_CYCLES);
    rst      = 1'b0;
    modelAcc = '0;
    modelOvf = 1'b0;
    idle(1);
    checkFlag("resultValid after reset", 1'b0, resultValid);
    checkFlag("overflow after reset", 1'b0, overflow);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    rst            = 1'b1;
    cmdValid       = 1'b0;
    cmdOp          = OP_NOP;
    a              = '0;
    b              = '0;
    cycle          = 0;
    valueErrors    = 0;
    protocolErrors = 0;
    modelAcc       = '0;
    modelOvf       = 1'b0;
    void'($urandom(SEED));

    testName = "reset";
    resetDut();
    issue(1'b1, OP_MAC, OP_W'($urandom % 64), OP_W'($urandom % 64)); // Just the product.
    idle(DRAIN_STEPS);

    testName = "exhaustive MUL";
    for (int ia = 0; ia < 64; ia++)
      for (int ib = 0; ib < 64; ib++)
        issue(1'b1, OP_MUL, OP_W'(ia), OP_W'(ib));
    idle(DRAIN_STEPS);

    testName = "accumulation";
    for (int run = 0; run < ACC_RUNS; run++)
    begin
      issue(1'b1, OP_CLR, '0, '0);
      repeat (ACC_LEN)
        issue(1'b1, OP_MAC, OP_W'($urandom % 64), OP_W'($urandom % 64));
    end
    idle(DRAIN_STEPS);

    testName = "overflow";
    issue(1'b1, OP_CLR, '0, '0);
    repeat (OVF_LEN)
      issue(1'b1, OP_MAC, OP_W'(48 + $urandom % 16), OP_W'(48 + $urandom % 16));
    idle(DRAIN_STEPS);
    checkFlag("overflow held", 1'b1, overflow);
    issue(1'b1, OP_CLR, '0, '0);
    idle(DRAIN_STEPS);
    checkFlag("overflow after CLR", 1'b0, overflow);

    testName = "mixed stream";
    repeat (MIX_LEN)
      issue(($urandom % 4) != 0, macOp'(2'($urandom % 4)),
            OP_W'($urandom % 64), OP_W'($urandom % 64));
    idle(DRAIN_STEPS);

    testName = "reset after traffic";
    repeat (OVF_LEN)
      issue(1'b1, OP_MAC, OP_W'(48 + $urandom % 16), OP_W'(48 + $urandom % 16));
    idle(DRAIN_STEPS);
    checkFlag("overflow before reset", 1'b1, overflow); // Reset must clear a set flag.
    resetDut();
    issue(1'b1, OP_MAC, OP_W'($urandom % 64), OP_W'($urandom % 64));
    idle(DRAIN_STEPS);

    $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
    if (valueErrors + protocolErrors == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+design
design/macPkg.sv
design/reduceIf.sv
design/partialProducts.sv
design/wallaceTree.sv
design/accumulator.sv
design/macControl.sv
design/macTop.sv
tests/clockGen.sv
tests/macTb.sv

/* run.sh */
#!/bin/sh
# Builds the MAC testbench with Verilator, runs it and scans the log.
verilator --binary --timing -f project.f --top-module macTb -o macSim > build.log 2>&1 \
  && ./obj_dir/macSim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
